// ==== src/bus_map_pkg.sv ====
// bus map definitions
// address windows, bus widths and access timing of the host bus bridge

package bus_map_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int ADDR_W    = 24;  // byte address
  localparam int DATA_W    = 16;
  localparam int SEL_W     = 2;   // byte lanes, bit 1 is the upper byte

  // chip ram geometry
  localparam int RAM_WORDS = 512;
  localparam int RAM_AW    = 9;   // word address bits

  // ------------------------------
  // address windows
  // ------------------------------
  localparam logic [ADDR_W-1:0] RAM_BASE    = 24'h000000;
  localparam logic [ADDR_W-1:0] RAM_LIMIT   = 24'h0003FF;
  localparam logic [ADDR_W-1:0] CUSTOM_BASE = 24'hDFF000;  // low 9 bits pick the register
  localparam logic [ADDR_W-1:0] CIA_BASE    = 24'hBFE000;  // rs on bits 11:8, low lane

  // cycles from strobe sample to ack
  localparam int FAST_WAIT = 2;
  localparam int CIA_WAIT  = 6;   // slow cia cycle

  typedef enum logic [1:0] {IDLE, ACCESS, WAIT, ACK} bus_state_e;

  typedef enum logic [1:0] {T_RAM, T_CUSTOM, T_CIA, T_NONE} target_e;

endpackage

// ==== src/chipset_pkg.sv ====
// chipset register definitions
// custom interrupt registers and cia register map

package chipset_pkg;

  // ------------------------------
  // custom register offsets
  // ------------------------------
  localparam logic [8:0] REG_INTENAR = 9'h01C;  // read enable mask
  localparam logic [8:0] REG_INTREQR = 9'h01E;  // read pending requests
  localparam logic [8:0] REG_INTENA  = 9'h09A;
  localparam logic [8:0] REG_INTREQ  = 9'h09C;

  // intena / intreq bit fields
  localparam int INT_SETCLR = 15;  // 1 sets, 0 clears
  localparam int INT_MASTER = 14;
  localparam int INT_PORTS  = 3;   // cia lands here
  localparam int INT_BITS   = 15;

  // ------------------------------
  // cia registers
  // ------------------------------
  typedef enum logic [3:0] {
    CIA_PRA  = 4'd0,
    CIA_TALO = 4'd4,
    CIA_TAHI = 4'd5,
    CIA_ICR  = 4'd13,
    CIA_CRA  = 4'd14
  } cia_reg_e;

  localparam int CRA_START   = 0;
  localparam int CRA_RUNMODE = 3;  // one-shot when set

  localparam int ICR_TA      = 0;  // timer a underflow
  localparam int ICR_SETCLR  = 7;

  // timer tick prescaler, stands in for the eclk
  localparam int ECLK_DIV = 10;

  localparam int IPL_W = 3;

endpackage

// ==== src/bus_bridge.sv ====
// host bus bridge
// wishbone classic slave, decodes the chipset windows and times each access
`timescale 1ns/100ps

module bus_bridge
  import bus_map_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [SEL_W-1:0]  wb_sel_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  input  logic [DATA_W-1:0] rd_data_i,    // or-combined responders
  output logic [DATA_W-1:0] wb_dat_o,
  output logic              wb_ack_o,
  output logic [ADDR_W-1:1] addr_o,       // word address
  output logic [DATA_W-1:0] wr_data_o,
  output logic              rd_o,
  output logic              hwr_o,
  output logic              lwr_o,
  output logic              ram_sel_o,
  output logic              custom_sel_o,
  output logic              cia_sel_o
);

  bus_state_e       state;
  target_e          target;      // latched decode
  target_e          target_dec;
  logic             we_q;
  logic [SEL_W-1:0] lanes_q;
  logic [2:0]       wait_cnt;
  logic             busy;

  // ------------------------------
  // address decode
  // ------------------------------
  always_comb begin
    if (wb_adr_i >= RAM_BASE && wb_adr_i <= RAM_LIMIT)
      target_dec = T_RAM;
    else if (wb_adr_i[ADDR_W-1:9] == CUSTOM_BASE[ADDR_W-1:9])
      target_dec = T_CUSTOM;
    else if (wb_adr_i[ADDR_W-1:12] == CIA_BASE[ADDR_W-1:12])
      target_dec = T_CIA;
    else
      target_dec = T_NONE;  // unmapped, reads zero
  end

  // ------------------------------
  // access sequencer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      target   <= T_NONE;
      wait_cnt <= '0;
    end else if (!wb_cyc_i) begin
      state <= IDLE;  // master gave up the cycle
    end else begin
      case (state)
        IDLE: if (wb_stb_i) begin
          state  <= ACCESS;
          target <= target_dec;
        end
        ACCESS: begin
          state    <= WAIT;
          // access cycle already counts one
          wait_cnt <= (target == T_CIA) ? 3'(CIA_WAIT - 2) : 3'(FAST_WAIT - 2);
        end
        WAIT: if (wait_cnt == '0)
          state <= ACK;
        else
          wait_cnt <= wait_cnt - 3'd1;
        ACK:     state <= IDLE;  // still the old request here
        default: state <= IDLE;
      endcase
    end
  end

  // request payload, held for the whole access
  always_ff @(posedge clk) begin
    if (state == IDLE && wb_cyc_i && wb_stb_i) begin
      addr_o    <= wb_adr_i[ADDR_W-1:1];
      we_q      <= wb_we_i;
      lanes_q   <= wb_sel_i;
      wr_data_o <= wb_dat_i;
    end
    if (state == WAIT && wait_cnt == '0)
      wb_dat_o <= rd_data_i;  // capture on the way into ack
  end

  assign busy = (state == ACCESS) || (state == WAIT);

  assign ram_sel_o    = busy && (target == T_RAM);
  assign custom_sel_o = busy && (target == T_CUSTOM);
  assign cia_sel_o    = busy && (target == T_CIA);

  // one-cycle strobes
  assign rd_o  = (state == ACCESS) && !we_q;
  assign hwr_o = (state == ACCESS) && we_q && lanes_q[1];
  assign lwr_o = (state == ACCESS) && we_q && lanes_q[0];

  assign wb_ack_o = (state == ACK);

  // one ack per request, never back to back
  ack_pulse_a: assert property (@(posedge clk) disable iff (reset)
    wb_ack_o |=> !wb_ack_o);

  sel_onehot_a: assert property (@(posedge clk) disable iff (reset)
    $onehot0({ram_sel_o, custom_sel_o, cia_sel_o}));

endmodule

// ==== src/chip_ram.sv ====
// chip ram
// synchronous word memory with separate upper and lower byte writes
`timescale 1ns/100ps

module chip_ram
  import bus_map_pkg::*;
(
  input  logic              clk,
  input  logic              sel_i,
  input  logic              rd_i,
  input  logic              hwr_i,
  input  logic              lwr_i,
  input  logic [RAM_AW-1:0] addr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  output logic [DATA_W-1:0] rd_data_o
);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [DATA_W-1:0] rd_q;
  logic              sel_q;  // selected last cycle

  always_ff @(posedge clk) begin
    // byte lanes, like the sram bhe/ble pair
    if (sel_i && hwr_i)
      mem[addr_i][15:8] <= wr_data_i[15:8];
    if (sel_i && lwr_i)
      mem[addr_i][7:0] <= wr_data_i[7:0];
  end

  always_ff @(posedge clk) begin
    sel_q <= sel_i;
    if (sel_i && rd_i)
      rd_q <= mem[addr_i];  // valid the cycle after the strobe
  end

  // or-bus, zero when idle
  assign rd_data_o = sel_q ? rd_q : '0;

endmodule

// ==== src/cia_port_timer.sv ====
// cia with port a, timer a and interrupt control
// port a bit 1 drives the power led, timer a underflow raises irq
`timescale 1ns/100ps

module cia_port_timer
  import chipset_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       sel_i,
  input  logic       rd_i,
  input  logic       wr_i,
  input  logic [3:0] rs_i,       // register select
  input  logic [7:0] wr_data_i,
  output logic [7:0] rd_data_o,
  output logic       pwrled_o,
  output logic       irq_o
);

  cia_reg_e    rs;
  logic        wr_en;
  logic        rd_en;
  logic        tahi_wr;
  logic        tick;       // timer clock enable
  logic [3:0]  presc;
  logic [7:0]  pra;
  logic [7:0]  cra;
  logic [15:0] ta_latch;
  logic [15:0] ta_cnt;
  logic        icr_ta;     // underflow flag
  logic        icr_mask_ta;
  logic [7:0]  icr_val;
  logic [7:0]  rd_q;
  logic        sel_q;

  assign rs      = cia_reg_e'(rs_i);
  assign wr_en   = sel_i && wr_i;
  assign rd_en   = sel_i && rd_i;
  assign tahi_wr = wr_en && (rs == CIA_TAHI);
  assign tick    = (presc == 4'(ECLK_DIV - 1));

  always_comb begin
    icr_val             = '0;
    icr_val[ICR_TA]     = icr_ta;
    icr_val[ICR_SETCLR] = icr_ta && icr_mask_ta;  // any enabled source
  end

  // ------------------------------
  // registers and timer a
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      presc       <= '0;
      pra         <= 8'hFF;  // led line idles high
      cra         <= '0;
      ta_latch    <= '1;
      ta_cnt      <= '1;
      icr_ta      <= 1'b0;
      icr_mask_ta <= 1'b0;
      irq_o       <= 1'b0;
      sel_q       <= 1'b0;
    end else begin
      presc <= tick ? 4'd0 : presc + 4'd1;
      sel_q <= sel_i;
      irq_o <= icr_ta && icr_mask_ta;

      if (rd_en && rs == CIA_ICR)
        icr_ta <= 1'b0;  // read clears flags

      if (cra[CRA_START] && tick) begin
        if (ta_cnt == '0) begin
          ta_cnt <= ta_latch;  // reload
          icr_ta <= 1'b1;
          if (cra[CRA_RUNMODE])
            cra[CRA_START] <= 1'b0;  // one-shot stops
        end else begin
          ta_cnt <= ta_cnt - 16'd1;
        end
      end

      // cpu writes win over the timer
      if (wr_en) begin
        case (rs)
          CIA_PRA:  pra <= wr_data_i;
          CIA_TALO: ta_latch[7:0] <= wr_data_i;
          CIA_TAHI: begin
            ta_latch[15:8] <= wr_data_i;
            ta_cnt         <= {wr_data_i, ta_latch[7:0]};
            if (cra[CRA_RUNMODE])
              cra[CRA_START] <= 1'b1;  // one-shot auto start
          end
          CIA_ICR: if (wr_data_i[ICR_TA])
            icr_mask_ta <= wr_data_i[ICR_SETCLR];
          CIA_CRA: cra <= wr_data_i;
          default: ;
        endcase
      end
    end
  end

  // read value taken before the icr clear lands
  always_ff @(posedge clk) begin
    if (rd_en) begin
      case (rs)
        CIA_PRA:  rd_q <= pra;
        CIA_TALO: rd_q <= ta_cnt[7:0];
        CIA_TAHI: rd_q <= ta_cnt[15:8];
        CIA_ICR:  rd_q <= icr_val;
        CIA_CRA:  rd_q <= cra;
        default:  rd_q <= '0;
      endcase
    end
  end

  assign rd_data_o = sel_q ? rd_q : '0;
  assign pwrled_o  = pra[1];  // _led

  // counter frozen while stopped, only a tahi load moves it
  cnt_hold_a: assert property (@(posedge clk) disable iff (reset)
    (!cra[CRA_START] && !tahi_wr) |=> $stable(ta_cnt));

endmodule

// ==== src/int_controller.sv ====
// interrupt controller
// intena/intreq registers, priority encoded onto the 68k ipl lines
`timescale 1ns/100ps

module int_controller
  import chipset_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             sel_i,
  input  logic             rd_i,
  input  logic             hwr_i,
  input  logic             lwr_i,
  input  logic [8:0]       reg_i,      // custom register offset
  input  logic [15:0]      wr_data_i,
  input  logic             cia_irq_i,  // level
  output logic [15:0]      rd_data_o,
  output logic [IPL_W-1:0] ipl_n_o
);

  logic [INT_BITS-1:0]   intena;
  logic [INT_BITS-1:0]   intreq;
  logic [INT_MASTER-1:0] active;
  logic [IPL_W-1:0]      level;
  logic                  wr_en;
  logic [15:0]           rd_q;
  logic                  sel_q;

  // bit 15 picks set or clear for the ones in the word
  function automatic logic [INT_BITS-1:0] set_clr(input logic [INT_BITS-1:0] cur,
                                                  input logic [15:0]         wd);
    if (wd[INT_SETCLR])
      return cur | wd[INT_BITS-1:0];
    else
      return cur & ~wd[INT_BITS-1:0];
  endfunction

  assign wr_en  = sel_i && (hwr_i || lwr_i);  // whole word on either lane
  assign active = intreq[INT_MASTER-1:0] & intena[INT_MASTER-1:0]
                  & {INT_MASTER{intena[INT_MASTER]}};

  // ------------------------------
  // priority, highest wins
  // ------------------------------
  always_comb begin
    level = '0;
    if (|active[2:0])       level = 3'd1;
    if (active[INT_PORTS])  level = 3'd2;
    if (|active[6:4])       level = 3'd3;
    if (|active[10:7])      level = 3'd4;
    if (|active[12:11])     level = 3'd5;
    if (active[13])         level = 3'd6;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      intena  <= '0;
      intreq  <= '0;
      ipl_n_o <= '1;  // no interrupt
      sel_q   <= 1'b0;
    end else begin
      sel_q   <= sel_i;
      ipl_n_o <= ~level;
      if (wr_en && reg_i == REG_INTENA)
        intena <= set_clr(intena, wr_data_i);
      if (wr_en && reg_i == REG_INTREQ)
        intreq <= set_clr(intreq, wr_data_i);
      if (cia_irq_i)
        intreq[INT_PORTS] <= 1'b1;  // reasserted while the cia holds it
    end
  end

  always_ff @(posedge clk) begin
    if (sel_i && rd_i) begin
      case (reg_i)
        REG_INTENAR: rd_q <= {1'b0, intena};
        REG_INTREQR: rd_q <= {1'b0, intreq};
        default:     rd_q <= '0;
      endcase
    end
  end

  assign rd_data_o = sel_q ? rd_q : '0;

  // master off keeps the cpu quiet one cycle later
  master_off_a: assert property (@(posedge clk) disable iff (reset)
    !intena[INT_MASTER] |=> (ipl_n_o == '1));

endmodule

// ==== src/minimig_lite.sv ====
// minimig lite top level
// host bus bridge, chip ram, interrupt controller and cia on an or-combined read bus
`timescale 1ns/100ps

module minimig_lite
  import bus_map_pkg::*;
  import chipset_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [ADDR_W-1:0] wb_adr_i,
  input  logic [SEL_W-1:0]  wb_sel_i,
  input  logic [DATA_W-1:0] wb_dat_i,
  output logic [DATA_W-1:0] wb_dat_o,
  output logic              wb_ack_o,
  output logic [IPL_W-1:0]  ipl_n_o,
  output logic              pwrled_o,
  output logic              rst_o
);

  logic [ADDR_W-1:1] addr;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] rd_data;
  logic [DATA_W-1:0] ram_rd_data;
  logic [DATA_W-1:0] int_rd_data;
  logic [7:0]        cia_rd_data;
  logic              rd;
  logic              hwr;
  logic              lwr;
  logic              ram_sel;
  logic              custom_sel;
  logic              cia_sel;
  logic              cia_irq;

  bus_bridge i_bus_bridge (
    .clk          (clk),
    .reset        (reset),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .rd_data_i    (rd_data),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .addr_o       (addr),
    .wr_data_o    (wr_data),
    .rd_o         (rd),
    .hwr_o        (hwr),
    .lwr_o        (lwr),
    .ram_sel_o    (ram_sel),
    .custom_sel_o (custom_sel),
    .cia_sel_o    (cia_sel)
  );

  chip_ram i_chip_ram (
    .clk       (clk),
    .sel_i     (ram_sel),
    .rd_i      (rd),
    .hwr_i     (hwr),
    .lwr_i     (lwr),
    .addr_i    (addr[RAM_AW:1]),
    .wr_data_i (wr_data),
    .rd_data_o (ram_rd_data)
  );

  int_controller i_int_controller (
    .clk       (clk),
    .reset     (reset),
    .sel_i     (custom_sel),
    .rd_i      (rd),
    .hwr_i     (hwr),
    .lwr_i     (lwr),
    .reg_i     ({addr[8:1], 1'b0}),  // byte offset in the custom page
    .wr_data_i (wr_data),
    .cia_irq_i (cia_irq),
    .rd_data_o (int_rd_data),
    .ipl_n_o   (ipl_n_o)
  );

  // cia sits on the low lane
  cia_port_timer i_cia_port_timer (
    .clk       (clk),
    .reset     (reset),
    .sel_i     (cia_sel),
    .rd_i      (rd),
    .wr_i      (hwr | lwr),
    .rs_i      (addr[11:8]),
    .wr_data_i (wr_data[7:0]),
    .rd_data_o (cia_rd_data),
    .pwrled_o  (pwrled_o),
    .irq_o     (cia_irq)
  );

  // ------------------------------
  // read bus, idle responders give zero
  // ------------------------------
  assign rd_data = ram_rd_data | int_rd_data | {8'h00, cia_rd_data};

  assign rst_o = reset;  // reset status

endmodule

// ==== dv/tb_minimig_lite.sv ====
// minimig lite testbench
// replays wishbone accesses from the vector file, checks read data, ack timing and ipl
`timescale 1ns/100ps

module tb_minimig_lite
  import bus_map_pkg::*;
  import chipset_pkg::*;
();

  localparam int POLL_MAX = 100;                      // reads before a poll gives up
  localparam logic [ADDR_W-1:0] PRA_ADR = CIA_BASE;   // rs 0

  logic              clk;
  logic              reset;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [ADDR_W-1:0] wb_adr;
  logic [SEL_W-1:0]  wb_sel;
  logic [DATA_W-1:0] wb_dat_w;
  logic [DATA_W-1:0] wb_dat_r;
  logic              wb_ack;
  logic [IPL_W-1:0]  ipl_n;
  logic              pwrled;
  logic              rst;

  // vector columns
  int                v_test[$];
  logic [7:0]        v_op[$];
  logic [ADDR_W-1:0] v_adr[$];
  logic [SEL_W-1:0]  v_sel[$];
  logic [DATA_W-1:0] v_wdat[$];
  logic [DATA_W-1:0] v_rdat[$];
  logic [IPL_W-1:0]  v_ipl[$];

  int cycle_cnt = 0;
  int cycle_limit = 0;
  int errors = 0;     // all failed checks
  int test_errs = 0;  // failed checks of the running test
  int tests_ok = 0;
  int tests_bad = 0;
  int cur_test = 0;

  minimig_lite i_minimig_lite (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_sel_i (wb_sel),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack),
    .ipl_n_o  (ipl_n),
    .pwrled_o (pwrled),
    .rst_o    (rst)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ------------------------------
  // run limit
  // ------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic count_failure();
    errors++;
    test_errs++;
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    int          t;
    string       line;
    logic [7:0]  op;
    logic [31:0] adr;
    logic [31:0] sel;
    logic [31:0] wd;
    logic [31:0] rd;
    logic [31:0] ipl;
    fd = $fopen("dv/minimig_lite_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/minimig_lite_vectors.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin  // skip the column notes
          n = $sscanf(line, "%d %c %h %h %h %h %h", t, op, adr, sel, wd, rd, ipl);
          if (n == 7) begin
            v_test.push_back(t);
            v_op.push_back(op);
            v_adr.push_back(adr[ADDR_W-1:0]);
            v_sel.push_back(sel[SEL_W-1:0]);
            v_wdat.push_back(wd[DATA_W-1:0]);
            v_rdat.push_back(rd[DATA_W-1:0]);
            v_ipl.push_back(ipl[IPL_W-1:0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one wishbone classic access that waits for ack
  task automatic bus_access(input  logic [ADDR_W-1:0] adr,
                            input  logic [SEL_W-1:0]  sel,
                            input  logic              we,
                            input  logic [DATA_W-1:0] wdat,
                            output logic [DATA_W-1:0] rdat);
    int edges;
    int lat_exp;
    edges = 0;
    // ack rises wait cycles after the sampling edge and is seen one edge later
    lat_exp = ((adr[ADDR_W-1:12] == CIA_BASE[ADDR_W-1:12]) ? CIA_WAIT : FAST_WAIT) + 2;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_sel   <= sel;
    wb_dat_w <= wdat;
    do begin
      @(posedge clk);
      edges++;
    end while (!wb_ack && edges < lat_exp + 20);
    if (!wb_ack) begin
      $display("test %0d: no ack for address %h after %0d cycles", cur_test, adr, edges);
      count_failure();
    end else if (edges != lat_exp) begin
      $display("test %0d: ack for address %h after %0d cycles instead of %0d",
               cur_test, adr, edges, lat_exp);
      count_failure();
    end
    rdat = wb_dat_r;
    wb_cyc <= 1'b0;  // cycle ends with the ack
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic run_vector(input int i);
    logic [DATA_W-1:0] rdat;
    int                tries;
    tries = 0;
    case (v_op[i])
      "W": begin
        bus_access(v_adr[i], v_sel[i], 1'b1, v_wdat[i], rdat);
        // led line is pra bit 1
        if (v_adr[i] == PRA_ADR && pwrled !== v_wdat[i][1]) begin
          $display("FAIL test %0d: pwrled_o got %h expected %h", cur_test, pwrled,
                   v_wdat[i][1]);
          count_failure();
        end
      end
      "R": begin
        bus_access(v_adr[i], v_sel[i], 1'b0, '0, rdat);
        if (rdat !== v_rdat[i]) begin
          $display("FAIL test %0d: wb_dat_o at %h got %h expected %h", cur_test, v_adr[i],
                   rdat, v_rdat[i]);
          count_failure();
        end
      end
      "P": begin
        do begin
          bus_access(v_adr[i], v_sel[i], 1'b0, '0, rdat);
          tries++;
        end while (rdat !== v_rdat[i] && tries < POLL_MAX);
        if (rdat !== v_rdat[i]) begin
          $display("test %0d: poll of %h gave up after %0d reads", cur_test, v_adr[i], tries);
          count_failure();
        end
      end
      default: begin
        $display("test %0d: unknown operation in vector %0d", cur_test, i);
        count_failure();
      end
    endcase
    if (ipl_n !== v_ipl[i]) begin
      $display("FAIL test %0d: ipl_n_o got %h expected %h", cur_test, ipl_n, v_ipl[i]);
      count_failure();
    end
    // reset is released for the whole vector run
    if (rst !== 1'b0) begin
      $display("FAIL test %0d: rst_o got %h expected %h", cur_test, rst, 1'b0);
      count_failure();
    end
  endtask

  task automatic close_test();
    if (test_errs == 0) begin
      tests_ok++;
      $display("test %0d ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %0d: %0d checks failed", cur_test, test_errs);
    end
    test_errs = 0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    load_vectors();
    cycle_limit = v_test.size() * (CIA_WAIT + POLL_MAX) + 100;
    cur_test = (v_test.size() > 0) ? v_test[0] : 0;  // reset checks count here
    repeat (10) begin
      @(posedge clk);
      if (rst !== 1'b1) begin
        $display("FAIL test %0d: rst_o got %h expected %h", cur_test, rst, 1'b1);
        count_failure();
      end
    end
    // reset state of the outputs
    if (ipl_n !== 3'b111) begin
      $display("FAIL test %0d: ipl_n_o got %h expected %h", cur_test, ipl_n, 3'b111);
      count_failure();
    end
    if (pwrled !== 1'b1) begin
      $display("FAIL test %0d: pwrled_o got %h expected %h", cur_test, pwrled, 1'b1);
      count_failure();
    end
    if (wb_ack !== 1'b0) begin
      $display("FAIL test %0d: wb_ack_o got %h expected %h", cur_test, wb_ack, 1'b0);
      count_failure();
    end
    reset <= 1'b0;
    foreach (v_test[i]) begin
      if (v_test[i] != cur_test) begin
        close_test();
        cur_test = v_test[i];
      end
      run_vector(i);
    end
    if (v_test.size() > 0)
      close_test();
    $display("%0d tests ok, %0d tests failed, %0d failed checks", tests_ok, tests_bad,
             errors);
    if (errors == 0 && v_test.size() > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== Bender.yml ====
package:
  name: minimig_lite

sources:
  - src/bus_map_pkg.sv
  - src/chipset_pkg.sv
  - src/bus_bridge.sv
  - src/chip_ram.sv
  - src/cia_port_timer.sv
  - src/int_controller.sv
  - src/minimig_lite.sv
  - target: simulation
    files:
      - dv/tb_minimig_lite.sv

// ==== minimig_lite.f ====
src/bus_map_pkg.sv
src/chipset_pkg.sv
src/bus_bridge.sv
src/chip_ram.sv
src/cia_port_timer.sv
src/int_controller.sv
src/minimig_lite.sv
dv/tb_minimig_lite.sv

// ==== dv/minimig_lite_vectors.txt ====
# test op addr sel wdata exp_rdata exp_ipl_n, op is W write, R read, P poll until exp_rdata
# addr, sel, data and ipl in hex, test number in decimal
6 R DFF01C 3 0000 0000 7
1 W 000010 3 1234 0000 7
1 W 000010 2 ABCD 0000 7
1 W 000010 1 99EF 0000 7
1 W 000012 3 5A5A 0000 7
1 R 000010 3 0000 ABEF 7
1 R 000012 3 0000 5A5A 7
1 R 400000 3 0000 0000 7
2 W DFF09A 3 8021 0000 7
2 R DFF01C 3 0000 0021 7
2 W DFF09A 3 0001 0000 7
2 R DFF01C 3 0000 0020 7
3 W DFF09A 3 E000 0000 7
3 W DFF09C 3 8020 0000 4
3 W DFF09C 3 A000 0000 1
3 R DFF01E 3 0000 2020 1
3 W DFF09A 3 4000 0000 7
4 W DFF09C 3 7FFF 0000 7
4 W DFF09A 3 7FFF 0000 7
4 W BFED00 1 0081 0000 7
4 W DFF09A 3 C008 0000 7
4 W BFEE00 1 0008 0000 7
4 W BFE400 1 0014 0000 7
4 W BFE500 1 0000 0000 7
4 P DFF01E 3 0000 0008 5
4 R BFED00 1 0000 0081 5
4 W DFF09C 3 0008 0000 7
4 R DFF01E 3 0000 0000 7
5 W BFE000 1 0002 0000 7
5 R BFE000 1 0000 0002 7
5 W BFE000 1 0000 0000 7
